/* design/kp_settings.svh */
`ifndef KP_SETTINGS_SVH
`define KP_SETTINGS_SVH

// consecutive cycles with a row active before a press is accepted
`define KP_DEBOUNCE_LEN 15

// cycles each column stays driven while the rows are idle
`define KP_SCAN_DWELL 4

// key codes kept in the entry buffer
`define KP_ENTRY_DEPTH 4

`endif

/* design/kp_pkg.sv */
`default_nettype none

`include "kp_settings.svh"

package kp_pkg;

    // alpha codes live in 16..31, so the top bit marks the bank
    typedef struct packed {
        logic       bank;
        logic [3:0] index;
    } key_split_t;

    // one 5-bit key code, read either whole or as bank plus index
    typedef union packed {
        logic [4:0] raw;
        key_split_t split;
    } key_code_t;

    // element 0 holds the newest key
    typedef key_code_t [`KP_ENTRY_DEPTH-1:0] entry_t;

    // special keys, both in the numeric half of the code space
    localparam logic [4:0] KEY_MODE  = 5'd10; // bank toggle
    localparam logic [4:0] KEY_CLEAR = 5'd11; // wipes the entry buffer

endpackage

`default_nettype wire

/* design/keypad_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface keypad_if;

    logic [3:0]        row;    // from the keypad pins
    logic [3:0]        column; // one-hot scan drive
    kp_pkg::key_code_t button; // decoded code of the active key
    logic              rising; // one-cycle press strobe
    logic              alpha;  // current bank, 1 = alpha

    modport scanner (
        input  row,
        output column
    );

    modport decoder (
        input  row,
        input  column,
        input  alpha,
        output button,
        output rising
    );

    // key entry owns the bank flag
    modport entry (
        input  button,
        input  rising,
        output alpha
    );

endinterface

`default_nettype wire

/* design/keypad_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kp_settings.svh"

module keypad_scanner (
    input logic       clk,
    input logic       rst,
    keypad_if.scanner kp
);

    localparam int CNT_W = (`KP_SCAN_DWELL > 1) ? $clog2(`KP_SCAN_DWELL) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`KP_SCAN_DWELL - 1);

    logic [CNT_W-1:0] dwell_cnt;
    logic             row_active;
    logic [3:0]       column_q;

    assign row_active = |kp.row;
    assign kp.column  = column_q;

    // dwell counter restarts whenever a key is seen so the next column
    // gets its full dwell after release
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            dwell_cnt <= '0;
        end else if (row_active) begin
            dwell_cnt <= '0;
        end else if (dwell_cnt == LAST) begin
            dwell_cnt <= '0;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            column_q <= 4'b1000;
        end else if (!row_active && dwell_cnt == LAST) begin
            column_q <= {column_q[0], column_q[3:1]}; // 1000 -> 0100 -> 0010 -> 0001
        end
    end

endmodule

`default_nettype wire

/* design/keypad_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kp_settings.svh"

module keypad_decoder (
    input logic       clk,
    input logic       rst,
    keypad_if.decoder kp
);

    localparam int DB_LEN = `KP_DEBOUNCE_LEN;

    logic              any_row;
    logic [DB_LEN-1:0] debounce;
    logic [DB_LEN:0]   db_next;
    logic              stable;
    logic              stable_d; // first edge stage
    logic              stable_q; // second edge stage
    kp_pkg::key_code_t code;

    assign any_row = |kp.row;

    // new sample enters at the top, oldest drops off bit 0
    assign db_next = {any_row, debounce};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            debounce <= '0;
        end else begin
            debounce <= db_next[DB_LEN:1];
        end
    end

    assign stable = &debounce; // full run of active samples

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            stable_d <= 1'b0;
            stable_q <= 1'b0;
        end else begin
            stable_d <= stable;
            stable_q <= stable_d;
        end
    end

    // a held key keeps stable high, so only the first cycle pulses
    assign kp.rising = stable_d & ~stable_q;

    always_comb begin
        code.raw = 5'd0; // anything not one-hot
        if (kp.alpha) begin
            case (kp.column)
                4'b1000: begin
                    case (kp.row)
                        4'b1000: code.raw = 5'd16;
                        4'b0100: code.raw = 5'd20;
                        4'b0010: code.raw = 5'd24;
                        4'b0001: code.raw = kp_pkg::KEY_MODE; // mode key in both banks
                        default: ;
                    endcase
                end
                4'b0100: begin
                    case (kp.row)
                        4'b1000: code.raw = 5'd17;
                        4'b0100: code.raw = 5'd21;
                        4'b0010: code.raw = 5'd25;
                        4'b0001: code.raw = 5'd29;
                        default: ;
                    endcase
                end
                4'b0010: begin
                    case (kp.row)
                        4'b1000: code.raw = 5'd18;
                        4'b0100: code.raw = 5'd22;
                        4'b0010: code.raw = 5'd26;
                        4'b0001: code.raw = 5'd30;
                        default: ;
                    endcase
                end
                4'b0001: begin
                    case (kp.row)
                        4'b1000: code.raw = 5'd19;
                        4'b0100: code.raw = 5'd23;
                        4'b0010: code.raw = 5'd27;
                        4'b0001: code.raw = 5'd31;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end else begin
            case (kp.column)
                4'b1000: begin
                    case (kp.row)
                        4'b1000: code.raw = 5'd7;
                        4'b0100: code.raw = 5'd4;
                        4'b0010: code.raw = 5'd1;
                        4'b0001: code.raw = kp_pkg::KEY_MODE;
                        default: ;
                    endcase
                end
                4'b0100: begin
                    case (kp.row)
                        4'b1000: code.raw = 5'd8;
                        4'b0100: code.raw = 5'd5;
                        4'b0010: code.raw = 5'd2;
                        4'b0001: code.raw = 5'd0;
                        default: ;
                    endcase
                end
                4'b0010: begin
                    case (kp.row)
                        4'b1000: code.raw = 5'd9;
                        4'b0100: code.raw = 5'd6;
                        4'b0010: code.raw = 5'd3;
                        4'b0001: code.raw = kp_pkg::KEY_CLEAR;
                        default: ;
                    endcase
                end
                4'b0001: begin
                    // right-hand column holds the extra keys 12..15
                    case (kp.row)
                        4'b1000: code.raw = 5'd12;
                        4'b0100: code.raw = 5'd13;
                        4'b0010: code.raw = 5'd14;
                        4'b0001: code.raw = 5'd15;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign kp.button = code;

endmodule

`default_nettype wire

/* design/key_entry.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kp_settings.svh"

module key_entry (
    input  logic              clk,
    input  logic              rst,
    keypad_if.entry           kp,
    output logic              key_valid,
    output kp_pkg::key_code_t key_code,
    output kp_pkg::entry_t    entry
);

    logic is_mode;
    logic is_clear;
    logic alpha_q;

    // special keys sit in the numeric half, so bank must be clear
    assign is_mode  = !kp.button.split.bank &&
                      (kp.button.split.index == kp_pkg::KEY_MODE[3:0]);
    assign is_clear = !kp.button.split.bank &&
                      (kp.button.split.index == kp_pkg::KEY_CLEAR[3:0]);

    assign kp.alpha = alpha_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            alpha_q   <= 1'b0;
            key_valid <= 1'b0;
            key_code  <= '0;
            entry     <= '0;
        end else begin
            key_valid <= 1'b0;
            if (kp.rising) begin
                if (is_mode) begin
                    alpha_q <= ~alpha_q;
                end else if (is_clear) begin
                    entry <= '0;
                end else begin
                    // older keys move up, the oldest falls out
                    for (int i = `KP_ENTRY_DEPTH - 1; i > 0; i--) begin
                        entry[i] <= entry[i-1];
                    end
                    entry[0]  <= kp.button;
                    key_code  <= kp.button;
                    key_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/keypad_entry.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kp_settings.svh"

module keypad_entry (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [3:0]                   row,
    output logic [3:0]                   column,
    output logic                         key_valid,
    output logic [4:0]                   key_code,
    output logic                         alpha,
    output logic [`KP_ENTRY_DEPTH*5-1:0] entry
);

    kp_pkg::key_code_t key_code_w;
    kp_pkg::entry_t    entry_w;

    keypad_if kp ();

    assign kp.row = row;
    assign column = kp.column;
    assign alpha  = kp.alpha;

    keypad_scanner u_scanner (
        .clk (clk),
        .rst (rst),
        .kp  (kp.scanner)
    );

    keypad_decoder u_decoder (
        .clk (clk),
        .rst (rst),
        .kp  (kp.decoder)
    );

    key_entry u_entry (
        .clk       (clk),
        .rst       (rst),
        .kp        (kp.entry),
        .key_valid (key_valid),
        .key_code  (key_code_w),
        .entry     (entry_w)
    );

    assign key_code = key_code_w.raw;
    assign entry    = entry_w; // flattened, element 0 in the low bits

endmodule

`default_nettype wire

/* testbench/keypad_entry_assert.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kp_settings.svh"

module keypad_entry_assert (
    input logic       clk,
    input logic       rst,
    input logic [3:0] row,
    input logic [3:0] column,
    input logic       key_valid
);

    int fail_count = 0; // polled by the testbench

    column_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(column))
        else begin
            fail_count++;
            $error("column drive is not one-hot: %b", column);
        end

    // the scanner must hold its column while a key is seen
    column_hold: assert property (@(posedge clk) disable iff (rst)
        (row != 4'b0000) |=> $stable(column))
        else begin
            fail_count++;
            $error("column moved while a row was active");
        end

    // a column that moves on has been driven for its whole dwell
    column_dwell: assert property (@(posedge clk) disable iff (rst)
        $changed(column) |-> ($past(column, `KP_SCAN_DWELL) == $past(column)))
        else begin
            fail_count++;
            $error("column moved before its dwell ran out");
        end

    valid_single: assert property (@(posedge clk) disable iff (rst)
        key_valid |=> !key_valid)
        else begin
            fail_count++;
            $error("key_valid lasted more than one cycle");
        end

    valid_in_reset: assert property (@(posedge clk) rst |-> !key_valid)
        else begin
            fail_count++;
            $error("key_valid high during reset");
        end

endmodule

bind keypad_entry keypad_entry_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .row       (row),
    .column    (column),
    .key_valid (key_valid)
);

`default_nettype wire

/* testbench/keypad_entry_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kp_settings.svh"

module keypad_entry_tb;

    localparam int DB_LEN   = `KP_DEBOUNCE_LEN;
    localparam int WAIT_MAX = 400; // cycles allowed for any single wait
    localparam int GAP      = DB_LEN + 5;

    logic              clk = 1'b0;
    logic              rst;
    logic [3:0]        row = 4'b0000;
    logic [3:0]        column;
    logic              key_valid;
    kp_pkg::key_code_t key_code;
    logic              alpha;
    kp_pkg::entry_t    entry;

    logic              key_down;
    logic [1:0]        key_row;
    logic [1:0]        key_col;
    int                run_len = 0; // consecutive cycles with a row active

    logic              exp_alpha;
    kp_pkg::key_code_t exp_code;
    kp_pkg::entry_t    exp_entry;
    int                exp_pulses;
    int                valid_count = 0;
    logic [31:0]       lfsr;

    keypad_entry uut (
        .clk       (clk),
        .rst       (rst),
        .row       (row),
        .column    (column),
        .key_valid (key_valid),
        .key_code  (key_code),
        .alpha     (alpha),
        .entry     (entry)
    );

    always #50 clk = ~clk;

    // keypad model where the pressed row only shows on its own column
    always @(posedge clk) begin
        if (key_down && column == (4'b1000 >> key_col)) begin
            row <= 4'b1000 >> key_row;
        end else begin
            row <= 4'b0000;
        end
        run_len <= (row != 4'b0000) ? run_len + 1 : 0;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_code(input kp_pkg::key_code_t got, input kp_pkg::key_code_t exp);
        if (got.raw !== exp.raw) begin
            abort_run($sformatf("[FAIL] %0t: key_code %0d, expected %0d",
                                $time, got.raw, exp.raw));
        end
    endtask

    task automatic check_entry(input kp_pkg::entry_t got, input kp_pkg::entry_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: entry %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_alpha(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: alpha %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_count();
        if (valid_count != exp_pulses) begin
            abort_run($sformatf("[FAIL] %0t: %0d key_valid pulses, expected %0d",
                                $time, valid_count, exp_pulses));
        end
    endtask

    // every key_valid is compared with the model
    always @(posedge clk) begin
        if (!rst && key_valid) begin
            check_code(key_code, exp_code);
            check_entry(entry, exp_entry);
            check_alpha(alpha, exp_alpha);
            valid_count <= valid_count + 1;
        end
        if (uut.u_assert.fail_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // key code for row position r and column position c
    function automatic logic [4:0] expected_code(input logic bank, input int r, input int c);
        if (bank && !(r == 3 && c == 0)) begin
            return 5'(16 + 4 * r + c);
        end
        if (r < 3 && c < 3) begin
            return 5'(7 - 3 * r + c); // digit block 1..9
        end
        if (c == 3) begin
            return 5'(12 + r);
        end
        return (c == 0) ? kp_pkg::KEY_MODE : (c == 1) ? 5'd0 : kp_pkg::KEY_CLEAR;
    endfunction

    task automatic wait_run(input int len);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run($sformatf("timeout: row never stayed active for %0d cycles", len));
            end
        end while (run_len < len);
    endtask

    task automatic wait_valid(input int r, input int c);
        int t;
        t = 0;
        while (valid_count != exp_pulses) begin
            @(posedge clk);
            t++;
            if (t > WAIT_MAX) begin
                abort_run($sformatf("no key_valid pulse for the key at row %0d column %0d",
                                    r, c));
            end
        end
    endtask

    // short row pulses that must not count as a press
    task automatic bounce_key(input int r, input int c, input int n);
        int len;
        int gap;
        key_row <= 2'(r);
        key_col <= 2'(c);
        for (int i = 0; i < n; i++) begin
            take_bits(3, len);
            take_bits(2, gap);
            key_down <= 1'b1;
            wait_run(len + 1);
            key_down <= 1'b0;
            repeat (gap + 3) @(posedge clk);
        end
    endtask

    task automatic press_key(input int r, input int c, input int bounces, input int hold);
        kp_pkg::key_code_t code;
        code.raw = expected_code(exp_alpha, r, c);
        if (code.raw == kp_pkg::KEY_MODE) begin
            exp_alpha = ~exp_alpha;
        end else if (code.raw == kp_pkg::KEY_CLEAR) begin
            exp_entry = '0;
        end else begin
            exp_entry  = {exp_entry[`KP_ENTRY_DEPTH-2:0], code}; // newest in element 0
            exp_code   = code;
            exp_pulses = exp_pulses + 1;
        end
        bounce_key(r, c, bounces);
        key_down <= 1'b1;
        wait_run(hold);
        wait_valid(r, c);
        key_down <= 1'b0;
        repeat (GAP) @(posedge clk); // release gap
        check_count();
        check_alpha(alpha, exp_alpha);
        check_entry(entry, exp_entry);
    endtask

    initial begin
        int r;
        int c;
        int nb;
        int extra;
        rst        = 1'b1;
        key_down   = 1'b0;
        key_row    = 2'd0;
        key_col    = 2'd0;
        exp_alpha  = 1'b0;
        exp_code   = '0;
        exp_entry  = '0;
        exp_pulses = 0;
        lfsr       = 32'h538a;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        check_alpha(alpha, 1'b0);
        check_entry(entry, '0);
        check_code(key_code, '0);
        repeat (200) @(posedge clk); // idle keypad
        check_count();

        for (r = 0; r < 4; r++) begin
            for (c = 0; c < 4; c++) begin
                if (!(r == 3 && (c == 0 || c == 2))) begin
                    press_key(r, c, 0, DB_LEN + 6);
                end
            end
        end

        bounce_key(2, 1, 4);
        repeat (GAP) @(posedge clk);
        check_count();
        press_key(1, 2, 3, 3 * DB_LEN); // long hold still reports once

        press_key(3, 0, 0, DB_LEN + 6);
        check_alpha(alpha, 1'b1);
        press_key(0, 0, 0, DB_LEN + 6);
        press_key(1, 2, 1, DB_LEN + 6);
        press_key(3, 2, 0, DB_LEN + 6); // clear position is a letter here
        press_key(3, 3, 0, DB_LEN + 6);
        press_key(3, 0, 1, DB_LEN + 6);
        check_alpha(alpha, 1'b0);

        press_key(3, 2, 0, DB_LEN + 6);
        check_entry(entry, '0);

        for (int n = 0; n < 300; n++) begin
            take_bits(2, r);
            take_bits(2, c);
            take_bits(2, nb);
            take_bits(3, extra);
            press_key(r, c, nb, DB_LEN + 6 + extra);
        end

        if (uut.u_assert.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

/* keypad_entry.f */
+incdir+design
design/kp_pkg.sv
design/keypad_if.sv
design/keypad_scanner.sv
design/keypad_decoder.sv
design/key_entry.sv
design/keypad_entry.sv
testbench/keypad_entry_assert.sv
testbench/keypad_entry_tb.sv

/* Makefile */
# Verilator build and run for the keypad_entry testbench

VERILATOR ?= verilator
TOP       ?= keypad_entry_tb
FILELIST  ?= keypad_entry.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
